// File: trace_settings.svh
// Entry count must be a power of two and TRACE_PTR_WIDTH must equal its base-two log

`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

////////////////////////////////////////
// Buffer geometry
////////////////////////////////////////

// Number of trace packets held in the circular buffer
`define TRACE_NUM_ENTRIES 64

// Entry index width, log2 of the entry count
`define TRACE_PTR_WIDTH 6

////////////////////////////////////////
// Debug transport
////////////////////////////////////////

// Debug-port address that loads the read pointer
// Writes to any other debug address are dropped
`define TRACE_DBG_RD_PTR_ADDR 7'h5D

`endif

// File: trace_pkg.sv
// Packet layout is fixed at four dwords and register offsets are byte addresses on a 5-bit bus

package trace_pkg;

    ////////////////////////////////////////
    // Trace packet and core report
    ////////////////////////////////////////

    // Stored packet, dword 0 in the low bits
    // Dword 3 carries the status bits with zero fill above bit 6
    typedef struct packed {
        logic [24:0] reserved;
        logic        interrupt;
        logic [4:0]  ecause;
        logic        exception;
        logic [31:0] tval;
        logic [31:0] address;
        logic [31:0] insn;
    } trace_packet_t;

    // Raw retire report from the core, one per cycle at most
    typedef struct packed {
        logic        valid;
        logic [31:0] insn;
        logic [31:0] address;
        logic        exception;
        logic [4:0]  ecause;
        logic        interrupt;
        logic [31:0] tval;
    } trace_report_t;

    ////////////////////////////////////////
    // Firmware register bus
    ////////////////////////////////////////

    // Single-cycle request strobe with byte strobes for writes
    typedef struct packed {
        logic        req;
        logic        write;
        logic [4:0]  addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } bus_req_t;

    // Response is valid in the request cycle
    typedef struct packed {
        logic [31:0] rdata;
        logic        error;
    } bus_rsp_t;

    // Register map, byte offsets
    typedef enum logic [4:0] {
        REG_STATUS = 5'h00,
        REG_CONFIG = 5'h04,
        REG_WR_PTR = 5'h08,
        REG_RD_PTR = 5'h0C,
        REG_DATA   = 5'h10
    } trace_reg_e;

    // Flat register view for the debug transport
    typedef struct packed {
        logic [31:0] status;
        logic [31:0] cfg;
        logic [31:0] wr_ptr;
        logic [31:0] rd_ptr;
        logic [31:0] data;
    } trace_dbg_view_t;

endpackage

// File: trace_capture.sv
// One report per cycle at most, no back-pressure, reports while debug_en is low are lost

`timescale 1ns/100ps

module trace_capture (
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic                    debug_en,
    input  trace_pkg::trace_report_t report,
    output logic                    wr_en,
    output trace_pkg::trace_packet_t packet
);

    // Qualified strobe and packed form of the current report
    logic                     capture;
    trace_pkg::trace_packet_t packet_next;

    ////////////////////////////////////////
    // Qualify and pack
    ////////////////////////////////////////

    // Only retired instructions seen in debug mode are traced
    assign capture = debug_en & report.valid;

    always_comb begin
        packet_next           = '0;
        packet_next.insn      = report.insn;
        packet_next.address   = report.address;
        packet_next.tval      = report.tval;
        packet_next.exception = report.exception;
        packet_next.ecause    = report.ecause;
        packet_next.interrupt = report.interrupt;
    end

    ////////////////////////////////////////
    // Retiming stage
    ////////////////////////////////////////

    // Strobe is control state and comes out of reset low
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= capture;
        end
    end

    // Payload follows every report, qualified or not
    always_ff @(posedge clk) begin
        packet <= packet_next;
    end

    // A store strobe only ever follows a cycle in debug mode
    wr_en_needs_debug_en: assert property (
        @(posedge clk) disable iff (!rst_b)
        $rose(wr_en) |-> $past(debug_en)
    );

endmodule

// File: trace_store.sv
// Read pointer bits above the entry index are ignored and the oldest entry is overwritten on wrap

`timescale 1ns/100ps

`include "trace_settings.svh"

module trace_store (
    input  logic                         clk,
    input  logic                         rst_b,
    input  logic                         wr_en,
    input  trace_pkg::trace_packet_t     packet,
    input  logic [31:0]                  rd_ptr,
    output logic [`TRACE_PTR_WIDTH-1:0]  wr_ptr,
    output logic                         valid_data,
    output logic                         wrapped,
    output logic [31:0]                  rd_dword
);

    localparam int PW = `TRACE_PTR_WIDTH;
    localparam int NUM_ENTRIES = `TRACE_NUM_ENTRIES;

    // Index of the final entry, where the write pointer rolls over
    localparam logic [PW-1:0] LAST_ENTRY = PW'(NUM_ENTRIES - 1);

    // Geometry sanity at elaboration
    if ((1 << PW) != NUM_ENTRIES) begin : g_geometry_check
        $error("Trace entry count must equal two to the power of the pointer width");
    end

    trace_pkg::trace_packet_t mem [NUM_ENTRIES];

    // Read side decode
    logic [PW-1:0]            rd_entry;
    logic [1:0]               rd_offset;
    trace_pkg::trace_packet_t rd_packet;

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    // Pointer advances by one per packet and wraps modulo the entry count
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_ptr     <= '0;
            valid_data <= 1'b0;
            wrapped    <= 1'b0;
        end else if (wr_en) begin
            wr_ptr     <= wr_ptr + 1'b1;
            valid_data <= 1'b1;
            if (wr_ptr == LAST_ENTRY) begin
                wrapped <= 1'b1;
            end
        end
    end

    // Buffer contents come out of reset cleared
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_ptr] <= packet;
        end
    end

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    // Dword pointer to entry and offset, four dwords per entry
    assign rd_entry  = rd_ptr[PW+1:2];
    assign rd_offset = rd_ptr[1:0];
    assign rd_packet = mem[rd_entry];

    // Combinational dword select
    assign rd_dword = rd_packet[rd_offset*32 +: 32];

    // Wrap flag is only ever set together with or after valid data
    wrapped_implies_valid: assert property (
        @(posedge clk) disable iff (!rst_b)
        wrapped |-> valid_data
    );

endmodule

// File: trace_regs.sv
// Single-cycle accesses, only RD_PTR is writable, nothing is reachable without debug_en

`timescale 1ns/100ps

`include "trace_settings.svh"

module trace_regs (
    input  logic                          clk,
    input  logic                          rst_b,
    input  logic                          debug_en,
    input  trace_pkg::bus_req_t           bus_req,
    output trace_pkg::bus_rsp_t           bus_rsp,
    input  logic                          dbg_wen,
    input  logic [6:0]                    dbg_addr,
    input  logic [31:0]                   dbg_wdata,
    output trace_pkg::trace_dbg_view_t    dbg_view,
    input  logic [`TRACE_PTR_WIDTH-1:0]   wr_ptr,
    input  logic                          valid_data,
    input  logic                          wrapped,
    input  logic [31:0]                   rd_dword,
    output logic [31:0]                   rd_ptr
);

    // Buffer depth in dwords, four per entry
    localparam logic [31:0] DEPTH_DWORDS = 32'(`TRACE_NUM_ENTRIES * 4);

    // Address decode
    trace_pkg::trace_reg_e      reg_addr;
    logic                       addr_hit;
    logic                       addr_is_rd_ptr;

    // Write qualification
    logic                       bus_err;
    logic                       bus_wr;
    logic                       dbg_wr;
    logic [31:0]                bus_biten;
    logic [31:0]                rd_ptr_strobed;

    // Read data before it joins the response
    logic [31:0]                rd_data;

    // Register contents before the debug gate
    trace_pkg::trace_dbg_view_t reg_view;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    assign reg_addr = trace_pkg::trace_reg_e'(bus_req.addr);

    always_comb begin
        case (reg_addr)
            trace_pkg::REG_STATUS,
            trace_pkg::REG_CONFIG,
            trace_pkg::REG_WR_PTR,
            trace_pkg::REG_RD_PTR,
            trace_pkg::REG_DATA:   addr_hit = 1'b1;
            default:               addr_hit = 1'b0;
        endcase
    end

    assign addr_is_rd_ptr = (reg_addr == trace_pkg::REG_RD_PTR);

    // Error on locked access, a hole in the map, or a write to a read-only register
    assign bus_err = bus_req.req
                   & (~debug_en | ~addr_hit | (bus_req.write & ~addr_is_rd_ptr));

    // Legal firmware write, always to RD_PTR
    assign bus_wr = bus_req.req & bus_req.write & ~bus_err;

    // Debug transport write hits only the read pointer address
    assign dbg_wr = debug_en & dbg_wen & (dbg_addr == `TRACE_DBG_RD_PTR_ADDR);

    ////////////////////////////////////////
    // Read pointer
    ////////////////////////////////////////

    // Expand byte strobes to a bit mask
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            bus_biten[b*8 +: 8] = {8{bus_req.wstrb[b]}};
        end
    end

    // Merge enabled bytes of the firmware write into the current value
    assign rd_ptr_strobed = (rd_ptr & ~bus_biten) | (bus_req.wdata & bus_biten);

    // Debug port has priority over firmware
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_ptr <= '0;
        end else if (dbg_wr) begin
            rd_ptr <= dbg_wdata;
        end else if (bus_wr) begin
            rd_ptr <= rd_ptr_strobed;
        end
    end

    ////////////////////////////////////////
    // Register contents
    ////////////////////////////////////////

    always_comb begin
        reg_view        = '0;
        reg_view.status = {30'b0, wrapped, valid_data};
        reg_view.cfg    = DEPTH_DWORDS;
        // Entry index scaled to dwords
        reg_view.wr_ptr = 32'({wr_ptr, 2'b00});
        reg_view.rd_ptr = rd_ptr;
        reg_view.data   = rd_dword;
    end

    // Read data only for a legal read, zero otherwise
    always_comb begin
        rd_data = '0;
        if (bus_req.req && !bus_req.write && !bus_err) begin
            case (reg_addr)
                trace_pkg::REG_STATUS: rd_data = reg_view.status;
                trace_pkg::REG_CONFIG: rd_data = reg_view.cfg;
                trace_pkg::REG_WR_PTR: rd_data = reg_view.wr_ptr;
                trace_pkg::REG_RD_PTR: rd_data = reg_view.rd_ptr;
                trace_pkg::REG_DATA:   rd_data = reg_view.data;
                default:               rd_data = '0;
            endcase
        end
    end

    assign bus_rsp.rdata = rd_data;
    assign bus_rsp.error = bus_err;

    // Debug transport sees nothing outside debug mode
    assign dbg_view = debug_en ? reg_view : '0;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    error_needs_req: assert property (
        @(posedge clk) disable iff (!rst_b)
        bus_rsp.error |-> bus_req.req
    );

    // A rejected write leaves the pointer alone unless the debug port moves it
    error_write_no_effect: assert property (
        @(posedge clk) disable iff (!rst_b)
        (bus_rsp.error && bus_req.write && !dbg_wr) |=> $stable(rd_ptr)
    );

endmodule

// File: trace_buffer_top.sv
// No fabric stall or handshake, so reports and bus requests are single-cycle strobes

`timescale 1ns/100ps

`include "trace_settings.svh"

module trace_buffer_top (
    input  logic                       clk,
    input  logic                       rst_b,
    input  logic                       debug_en,
    input  trace_pkg::trace_report_t   report,
    input  trace_pkg::bus_req_t        bus_req,
    output trace_pkg::bus_rsp_t        bus_rsp,
    input  logic                       dbg_wen,
    input  logic [6:0]                 dbg_addr,
    input  logic [31:0]                dbg_wdata,
    output trace_pkg::trace_dbg_view_t dbg_view
);

    // Capture to store
    logic                              wr_en;
    trace_pkg::trace_packet_t          packet;

    // Store to register block and back
    logic [`TRACE_PTR_WIDTH-1:0]       wr_ptr;
    logic                              valid_data;
    logic                              wrapped;
    logic [31:0]                       rd_dword;
    logic [31:0]                       rd_ptr;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////

    trace_capture u_capture (
        .clk      (clk),
        .rst_b    (rst_b),
        .debug_en (debug_en),
        .report   (report),
        .wr_en    (wr_en),
        .packet   (packet)
    );

    ////////////////////////////////////////
    // Circular buffer
    ////////////////////////////////////////

    trace_store u_store (
        .clk        (clk),
        .rst_b      (rst_b),
        .wr_en      (wr_en),
        .packet     (packet),
        .rd_ptr     (rd_ptr),
        .wr_ptr     (wr_ptr),
        .valid_data (valid_data),
        .wrapped    (wrapped),
        .rd_dword   (rd_dword)
    );

    ////////////////////////////////////////
    // Firmware and debug access
    ////////////////////////////////////////

    trace_regs u_regs (
        .clk        (clk),
        .rst_b      (rst_b),
        .debug_en   (debug_en),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .dbg_wen    (dbg_wen),
        .dbg_addr   (dbg_addr),
        .dbg_wdata  (dbg_wdata),
        .dbg_view   (dbg_view),
        .wr_ptr     (wr_ptr),
        .valid_data (valid_data),
        .wrapped    (wrapped),
        .rd_dword   (rd_dword),
        .rd_ptr     (rd_ptr)
    );

endmodule

// File: tb_trace_buffer.sv
// Self-checking testbench, fixed LFSR seed, entry count taken from the settings header

`timescale 1ns/100ps

`include "trace_settings.svh"

module tb_trace_buffer;

    localparam int NUM = `TRACE_NUM_ENTRIES;

    // Cycle budget per phase: reset, random fill, wrap fill, locked, debug port, bus errors
    localparam int RUN_CYCLES = 3 + (45 + 8 * 40 + 4) + (NUM + 11 + 8 * NUM + 4) + 30 + 12 + 130;

    logic                       clk;
    logic                       rst_b;
    logic                       debug_en;
    trace_pkg::trace_report_t   report;
    trace_pkg::bus_req_t        bus_req;
    trace_pkg::bus_rsp_t        bus_rsp;
    logic                       dbg_wen;
    logic [6:0]                 dbg_addr;
    logic [31:0]                dbg_wdata;
    trace_pkg::trace_dbg_view_t dbg_view;

    // Reference model state
    trace_pkg::trace_packet_t   model_mem [NUM];
    trace_pkg::trace_packet_t   pend_pkt;
    logic                       pend_valid;
    int                         model_wr_idx;
    logic                       model_valid;
    logic                       model_wrapped;
    logic [31:0]                model_rd_ptr;

    logic [31:0]                lfsr = 32'h899c475a;
    int                         errors = 0;

    trace_buffer_top UUT (
        .clk       (clk),
        .rst_b     (rst_b),
        .debug_en  (debug_en),
        .report    (report),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .dbg_wen   (dbg_wen),
        .dbg_addr  (dbg_addr),
        .dbg_wdata (dbg_wdata),
        .dbg_view  (dbg_view)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Galois LFSR, right-shifting form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s actual %h expected %h at %0t", name, actual, expected, $time);
            errors++;
        end
    endtask

    function automatic logic is_mapped(input logic [4:0] addr);
        return addr inside {5'h00, 5'h04, 5'h08, 5'h0C, 5'h10};
    endfunction

    // Register value as the register map defines it
    function automatic logic [31:0] expected_reg(input logic [4:0] addr);
        trace_pkg::trace_packet_t pkt;
        int                       entry;
        entry = int'((model_rd_ptr >> 2) % NUM);
        pkt   = model_mem[entry];
        case (addr)
            5'h00: return {30'b0, model_wrapped, model_valid};
            5'h04: return 32'(NUM * 4);
            5'h08: return 32'(model_wr_idx * 4);
            5'h0C: return model_rd_ptr;
            5'h10: begin
                case (model_rd_ptr[1:0])
                    2'd0:    return pkt.insn;
                    2'd1:    return pkt.address;
                    2'd2:    return pkt.tval;
                    default: return {25'b0, pkt.interrupt, pkt.ecause, pkt.exception};
                endcase
            end
            default: return 32'h0;
        endcase
    endfunction

    // Model step at a rising edge, inputs still hold what was driven before it
    task automatic model_edge();
        logic [31:0] mask;
        mask = {{8{bus_req.wstrb[3]}}, {8{bus_req.wstrb[2]}},
                {8{bus_req.wstrb[1]}}, {8{bus_req.wstrb[0]}}};
        // Second stage lands in the buffer
        if (pend_valid) begin
            model_mem[model_wr_idx] = pend_pkt;
            model_valid = 1'b1;
            if (model_wr_idx == NUM - 1) model_wrapped = 1'b1;
            model_wr_idx = (model_wr_idx + 1) % NUM;
        end
        // First stage takes a qualified report
        pend_valid = debug_en && report.valid;
        pend_pkt = '0;
        pend_pkt.insn = report.insn;
        pend_pkt.address = report.address;
        pend_pkt.tval = report.tval;
        pend_pkt.exception = report.exception;
        pend_pkt.ecause = report.ecause;
        pend_pkt.interrupt = report.interrupt;
        // Debug port first, then a legal firmware write
        if (debug_en && dbg_wen && dbg_addr == `TRACE_DBG_RD_PTR_ADDR) begin
            model_rd_ptr = dbg_wdata;
        end else if (debug_en && bus_req.req && bus_req.write && bus_req.addr == 5'h0C) begin
            model_rd_ptr = (model_rd_ptr & ~mask) | (bus_req.wdata & mask);
        end
    endtask

    // Advance one clock and land 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        if (rst_b) model_edge();
        #2;
    endtask

    // Debug view is zero outside debug mode
    task automatic check_view();
        check_value("dbg_view.status", dbg_view.status, debug_en ? expected_reg(5'h00) : 32'h0);
        check_value("dbg_view.cfg", dbg_view.cfg, debug_en ? expected_reg(5'h04) : 32'h0);
        check_value("dbg_view.wr_ptr", dbg_view.wr_ptr, debug_en ? expected_reg(5'h08) : 32'h0);
        check_value("dbg_view.rd_ptr", dbg_view.rd_ptr, debug_en ? expected_reg(5'h0C) : 32'h0);
        check_value("dbg_view.data", dbg_view.data, debug_en ? expected_reg(5'h10) : 32'h0);
    endtask

    // One bus request, response sampled mid-cycle
    task automatic bus_op(input logic write, input logic [4:0] addr,
                          input logic [31:0] wdata, input logic [3:0] wstrb);
        logic exp_err;
        bus_req.req   = 1'b1;
        bus_req.write = write;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        bus_req.wstrb = wstrb;
        #8;
        exp_err = !debug_en || !is_mapped(addr) || (write && addr != 5'h0C);
        check_value("bus_rsp.error", 32'(bus_rsp.error), 32'(exp_err));
        if (!write && !exp_err) begin
            check_value("bus_rsp.rdata", bus_rsp.rdata, expected_reg(addr));
        end
        check_view();
        next_cycle();
        bus_req = '0;
    endtask

    // Random report, valid from the LFSR unless forced
    task automatic send_report(input logic force_valid);
        logic [31:0] v;
        take_bits(1, v);
        report.valid = force_valid | v[0];
        take_bits(32, v);
        report.insn = v;
        take_bits(32, v);
        report.address = v;
        take_bits(32, v);
        report.tval = v;
        take_bits(7, v);
        report.exception = v[0];
        report.ecause = v[5:1];
        report.interrupt = v[6];
        next_cycle();
        // Pointer, flags and stored data track the capture pipeline every cycle
        check_view();
    endtask

    task automatic dbg_write(input logic [6:0] addr, input logic [31:0] data);
        dbg_wen   = 1'b1;
        dbg_addr  = addr;
        dbg_wdata = data;
        next_cycle();
        dbg_wen   = 1'b0;
    endtask

    // Walk every dword of the first count entries
    task automatic read_entries(input int count);
        for (int e = 0; e < count; e++) begin
            for (int off = 0; off < 4; off++) begin
                bus_op(1'b1, 5'h0C, 32'(e * 4 + off), 4'hF);
                bus_op(1'b0, 5'h10, 32'h0, 4'h0);
            end
        end
    endtask

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    initial begin
        #(RUN_CYCLES * 20 + 4000);
        $display("Timeout: the tests did not finish within %0d cycles", RUN_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] d;
        logic [31:0] s;
        logic [31:0] k;
        rst_b = 1'b0;
        debug_en = 1'b0;
        report = '0;
        bus_req = '0;
        dbg_wen = 1'b0;
        dbg_addr = '0;
        dbg_wdata = '0;
        for (int i = 0; i < NUM; i++) model_mem[i] = '0;
        pend_pkt = '0;
        pend_valid = 1'b0;
        model_wr_idx = 0;
        model_valid = 1'b0;
        model_wrapped = 1'b0;
        model_rd_ptr = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_b = 1'b1;
        debug_en = 1'b1;

        // Random reports, then each packet read back in order
        for (int i = 0; i < 40; i++) send_report(1'b0);
        report.valid = 1'b0;
        repeat (2) next_cycle();
        bus_op(1'b0, 5'h00, 32'h0, 4'h0);
        bus_op(1'b0, 5'h04, 32'h0, 4'h0);
        read_entries(model_wr_idx);

        // Back-to-back reports past the entry count, wrap overwrites the oldest
        for (int i = 0; i < NUM + 6; i++) send_report(1'b1);
        report.valid = 1'b0;
        repeat (2) next_cycle();
        bus_op(1'b0, 5'h00, 32'h0, 4'h0);
        bus_op(1'b0, 5'h08, 32'h0, 4'h0);
        read_entries(NUM);

        // Locked: no capture, every access errors, debug port ignored
        debug_en = 1'b0;
        for (int i = 0; i < 10; i++) send_report(1'b1);
        report.valid = 1'b0;
        repeat (2) next_cycle();
        for (int r = 0; r < 5; r++) bus_op(1'b0, 5'(r * 4), 32'h0, 4'h0);
        bus_op(1'b1, 5'h0C, 32'h1234_5678, 4'hF);
        dbg_write(`TRACE_DBG_RD_PTR_ADDR, 32'h0000_0055);
        debug_en = 1'b1;
        for (int r = 0; r < 5; r++) bus_op(1'b0, 5'(r * 4), 32'h0, 4'h0);

        // Debug port moves RD_PTR only at its own address and beats the bus
        take_bits(32, d);
        dbg_write(`TRACE_DBG_RD_PTR_ADDR, d);
        bus_op(1'b0, 5'h0C, 32'h0, 4'h0);
        take_bits(32, d);
        dbg_write(7'h10, d);
        bus_op(1'b0, 5'h0C, 32'h0, 4'h0);
        take_bits(32, d);
        dbg_wen = 1'b1;
        dbg_addr = `TRACE_DBG_RD_PTR_ADDR;
        dbg_wdata = d;
        bus_op(1'b1, 5'h0C, ~d, 4'hF);
        dbg_wen = 1'b0;
        bus_op(1'b0, 5'h0C, 32'h0, 4'h0);

        // Random accesses, half of them strobed RD_PTR writes
        for (int i = 0; i < 60; i++) begin
            take_bits(5, a);
            take_bits(1, w);
            take_bits(32, d);
            take_bits(4, s);
            take_bits(1, k);
            if (k[0]) begin
                bus_op(1'b1, 5'h0C, d, s[3:0]);
            end else begin
                bus_op(w[0], a[4:0], d, s[3:0]);
            end
            bus_op(1'b0, 5'h0C, 32'h0, 4'h0);
        end

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
trace_pkg.sv
trace_capture.sv
trace_store.sv
trace_regs.sv
trace_buffer_top.sv
tb_trace_buffer.sv

// File: Makefile
TOP := tb_trace_buffer

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
